//--- uart_emu_top.f
+incdir+include
src/uart_emu_pkg.sv
src/uart_char_fifo.sv
src/uart_axil_slave.sv
src/uart_ctrl_status.sv
src/uart_emu_top.sv
dv/uart_emu_tb.sv

//--- Makefile
# Verilator build and run of the UART emulation testbench

VERILATOR ?= verilator
TOP       ?= uart_emu_tb
FILELIST  ?= uart_emu_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing -j $(JOBS)
PASS_MSG  ?= TB PASSED

SOURCES   := $(shell grep -v '^+' $(FILELIST)) include/uart_emu_settings.svh
DATA      := dv/uart_emu_testdata.txt
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(DATA)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/uart_emu_testdata.txt
# op addr data resp strb rep, all fields hex
# C/T data is the char, H data is tx_ready, I data is the intr count, rep steps data by one
R 8 04 0 f 1
C 0 41 0 f 3
R 0 41 0 f 3
R 0 00 2 f 1
# receive overrun and clear
C 0 60 0 f 11
R 8 27 0 f 1
R 8 07 0 f 1
W c 02 0 f 1
R 8 04 0 f 1
# transmit full and drain
H 0 00 0 f 1
W 4 80 0 f 10
W 4 90 2 f 1
R 8 08 0 f 1
H 0 01 0 f 1
T 0 80 0 f 10
R 8 04 0 f 1
# control clears and strobe bit 0
H 0 00 0 f 1
W 4 a0 0 f 3
R 8 00 0 f 1
W c 01 0 f 1
R 8 04 0 f 1
W 4 b0 0 0 1
R 8 04 0 f 1
C 0 55 0 f 1
W c 02 0 0 1
R 8 05 0 f 1
R 0 55 0 f 1
# interrupt edges
I 0 00 0 f 1
W c 10 0 f 1
R 8 14 0 f 1
R c 10 0 f 1
C 0 31 0 f 1
I 0 01 0 f 1
R 0 31 0 f 1
W 4 32 0 f 1
H 0 01 0 f 1
T 0 32 0 f 1
I 0 02 0 f 1
W c 00 0 f 1
C 0 33 0 f 1
R 0 33 0 f 1
W 4 34 0 f 1
T 0 34 0 f 1
I 0 02 0 f 1

//--- dv/uart_emu_tb.sv
`timescale 1ns/1ps

`include "uart_emu_settings.svh"

module uart_emu_tb;

    localparam int    CLK_PERIOD      = 100;
    localparam int    CYCLES_PER_LINE = 200;
    localparam string DATA_FILE       = "dv/uart_emu_testdata.txt";

    // One parsed line of the stimulus file
    typedef struct packed {
        logic [7:0]              code;
        logic [`UART_ADDR_W-1:0] addr;
        logic [31:0]             data;
        logic [1:0]              resp;
        logic [3:0]              strb;
        logic [31:0]             rep;
        logic [31:0]             line_no;
    } test_op_t;

    logic                     clk;
    logic                     rst;
    logic                     aw_valid;
    logic                     aw_ready;
    uart_emu_pkg::axil_aw_t   aw;
    logic                     w_valid;
    logic                     w_ready;
    uart_emu_pkg::axil_w_t    w;
    logic                     b_valid;
    logic                     b_ready;
    uart_emu_pkg::axil_b_t    b;
    logic                     ar_valid;
    logic                     ar_ready;
    uart_emu_pkg::axil_ar_t   ar;
    logic                     r_valid;
    logic                     r_ready;
    uart_emu_pkg::axil_r_t    r;
    logic                     rx_valid;
    uart_emu_pkg::uart_char_t rx_ch;
    logic                     tx_valid;
    uart_emu_pkg::uart_char_t tx_ch;
    logic                     tx_ready;
    logic                     intr;

    test_op_t                 ops[$];
    uart_emu_pkg::uart_char_t tx_seen[$];
    int                       intr_count;
    int                       file_lines;
    bit                       ops_loaded;

    uart_emu_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Transmitted bytes and interrupt pulses are collected all the time
    always @(posedge clk) begin
        if (!rst && tx_valid && tx_ready) begin
            tx_seen.push_back(tx_ch);
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            intr_count <= 0;
        end else if (intr) begin
            intr_count <= intr_count + 1;
        end
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_read(input string name, input uart_emu_pkg::axil_r_t exp_rsp,
                              input uart_emu_pkg::axil_r_t act_rsp);
        if (act_rsp !== exp_rsp) begin
            stop_run($sformatf("** Error %s: expected data %h resp %h, actual data %h resp %h",
                               name, exp_rsp.data, exp_rsp.resp, act_rsp.data, act_rsp.resp));
        end
    endtask

    task automatic check_resp(input string name, input uart_emu_pkg::axil_b_t exp_rsp,
                              input uart_emu_pkg::axil_b_t act_rsp);
        if (act_rsp !== exp_rsp) begin
            stop_run($sformatf("** Error %s: expected bresp %h, actual bresp %h",
                               name, exp_rsp.resp, act_rsp.resp));
        end
    endtask

    task automatic check_char(input string name, input uart_emu_pkg::uart_char_t exp_ch,
                              input uart_emu_pkg::uart_char_t act_ch);
        if (act_ch !== exp_ch) begin
            stop_run($sformatf("** Error %s: expected char %h, actual char %h",
                               name, exp_ch, act_ch));
        end
    endtask

    task automatic check_count(input string name, input int exp_cnt, input int act_cnt);
        if (act_cnt != exp_cnt) begin
            stop_run($sformatf("** Error %s: expected count %0d, actual count %0d",
                               name, exp_cnt, act_cnt));
        end
    endtask

    function automatic bit ready_draw();
        return ($urandom % 4) != 0;
    endfunction

    task automatic axi_write(input logic [`UART_ADDR_W-1:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output uart_emu_pkg::axil_b_t rsp);
        @(posedge clk);
        aw_valid <= 1'b1;
        aw.addr  <= addr;
        @(posedge clk);
        while (!aw_ready) begin
            @(posedge clk);
        end
        aw_valid <= 1'b0;
        w_valid  <= 1'b1;
        w.data   <= data;
        w.strb   <= strb;
        @(posedge clk);
        while (!w_ready) begin
            @(posedge clk);
        end
        w_valid <= 1'b0;
        b_ready <= ready_draw();
        forever begin
            @(posedge clk);
            if (b_valid && b_ready) begin
                break;
            end
            b_ready <= ready_draw();
        end
        rsp = b;
        b_ready <= 1'b0;
    endtask

    task automatic axi_read(input logic [`UART_ADDR_W-1:0] addr,
                            output uart_emu_pkg::axil_r_t rsp);
        @(posedge clk);
        ar_valid <= 1'b1;
        ar.addr  <= addr;
        @(posedge clk);
        while (!ar_ready) begin
            @(posedge clk);
        end
        ar_valid <= 1'b0;
        r_ready  <= ready_draw();
        forever begin
            @(posedge clk);
            if (r_valid && r_ready) begin
                break;
            end
            r_ready <= ready_draw();
        end
        rsp = r;
        r_ready <= 1'b0;
    endtask

    task automatic inject_char(input uart_emu_pkg::uart_char_t ch);
        @(posedge clk);
        rx_valid <= 1'b1;
        rx_ch    <= ch;
        @(posedge clk);
        rx_valid <= 1'b0;
    endtask

    // Negedge polling keeps clear of the monitor's posedge update
    task automatic wait_tx_char(output uart_emu_pkg::uart_char_t ch);
        @(negedge clk);
        while (tx_seen.size() == 0) begin
            @(negedge clk);
        end
        ch = tx_seen.pop_front();
    endtask

    task automatic load_ops();
        int          fd;
        int          n;
        string       line;
        string       code;
        logic [31:0] f_addr;
        logic [31:0] f_data;
        logic [31:0] f_resp;
        logic [31:0] f_strb;
        logic [31:0] f_rep;
        test_op_t    op;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            stop_run($sformatf("Cannot open %s for reading", DATA_FILE));
        end else begin
            while ($fgets(line, fd) != 0) begin
                file_lines++;
                n = $sscanf(line, "%s %h %h %h %h %h",
                            code, f_addr, f_data, f_resp, f_strb, f_rep);
                if (n >= 1 && code.getc(0) != "#") begin
                    if (n != 6) begin
                        stop_run($sformatf("Line %0d of %s has %0d fields instead of 6",
                                           file_lines, DATA_FILE, n));
                    end else begin
                        op.code    = code.getc(0);
                        op.addr    = f_addr[`UART_ADDR_W-1:0];
                        op.data    = f_data;
                        op.resp    = f_resp[1:0];
                        op.strb    = f_strb[3:0];
                        op.rep     = f_rep;
                        op.line_no = file_lines;
                        ops.push_back(op);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_op(input test_op_t op);
        string                    name;
        logic [31:0]              k;
        uart_emu_pkg::axil_b_t    b_exp;
        uart_emu_pkg::axil_b_t    b_act;
        uart_emu_pkg::axil_r_t    r_exp;
        uart_emu_pkg::axil_r_t    r_act;
        uart_emu_pkg::uart_char_t ch;
        name = $sformatf("line %0d op %c", op.line_no, op.code);
        case (op.code)
            "W": begin
                for (k = 0; k < op.rep; k++) begin
                    axi_write(op.addr, op.data + k, op.strb, b_act);
                    b_exp.resp = op.resp;
                    check_resp(name, b_exp, b_act);
                end
            end
            "R": begin
                for (k = 0; k < op.rep; k++) begin
                    axi_read(op.addr, r_act);
                    r_exp.data = op.data + k;
                    r_exp.resp = op.resp;
                    check_read(name, r_exp, r_act);
                end
            end
            "C": begin
                for (k = 0; k < op.rep; k++) begin
                    inject_char(op.data[7:0] + k[7:0]);
                end
            end
            "T": begin
                for (k = 0; k < op.rep; k++) begin
                    wait_tx_char(ch);
                    check_char(name, op.data[7:0] + k[7:0], ch);
                end
            end
            "H": begin
                @(posedge clk);
                tx_ready <= op.data[0];
            end
            "I": begin
                // Pulse lands two edges after the FIFO flag changes
                repeat (4) @(posedge clk);
                @(negedge clk);
                check_count(name, int'(op.data), intr_count);
            end
            default: stop_run($sformatf("Unknown operation on line %0d", op.line_no));
        endcase
    endtask

    initial begin
        wait (ops_loaded);
        #(file_lines * CYCLES_PER_LINE * CLK_PERIOD);
        stop_run($sformatf("Timeout after %0d cycles, the DUT stopped responding",
                           file_lines * CYCLES_PER_LINE));
    end

    initial begin
        int seed_value;
        rst      = 1'b1;
        aw_valid = 1'b0;
        aw       = '0;
        w_valid  = 1'b0;
        w        = '0;
        b_ready  = 1'b0;
        ar_valid = 1'b0;
        ar       = '0;
        r_ready  = 1'b0;
        rx_valid = 1'b0;
        rx_ch    = '0;
        tx_ready = 1'b0;
        seed_value = $urandom(32'h02c120b6);
        load_ops();
        ops_loaded = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        foreach (ops[i]) begin
            run_op(ops[i]);
        end
        check_count("tx bytes left over", 0, tx_seen.size());
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- src/uart_emu_top.sv
`timescale 1ns/1ps

`include "uart_emu_settings.svh"

module uart_emu_top (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     aw_valid,
    output logic                     aw_ready,
    input  uart_emu_pkg::axil_aw_t   aw,
    input  logic                     w_valid,
    output logic                     w_ready,
    input  uart_emu_pkg::axil_w_t    w,
    output logic                     b_valid,
    input  logic                     b_ready,
    output uart_emu_pkg::axil_b_t    b,
    input  logic                     ar_valid,
    output logic                     ar_ready,
    input  uart_emu_pkg::axil_ar_t   ar,
    output logic                     r_valid,
    input  logic                     r_ready,
    output uart_emu_pkg::axil_r_t    r,

    input  logic                     rx_valid,
    input  uart_emu_pkg::uart_char_t rx_ch,
    output logic                     tx_valid,
    output uart_emu_pkg::uart_char_t tx_ch,
    input  logic                     tx_ready,
    output logic                     intr
);

    uart_emu_pkg::uart_rd_req_t rd_req;
    uart_emu_pkg::uart_wr_req_t wr_req;
    uart_emu_pkg::axil_r_t      rd_rsp;
    uart_emu_pkg::uart_char_t   rx_data;
    uart_emu_pkg::uart_char_t   tx_data;

    logic wr_err;
    logic rx_in_ready;
    logic rx_avail;
    logic rx_pop;
    logic rx_clear;
    logic rx_drop;
    logic tx_in_ready;
    logic tx_push;
    logic tx_clear;

    // Receive strobe has no ready, so a full FIFO loses the character
    assign rx_drop = rx_valid && !rx_in_ready;

    uart_axil_slave u_slave (
        .clk      (clk),
        .rst      (rst),
        .aw_valid (aw_valid),
        .aw_ready (aw_ready),
        .aw       (aw),
        .w_valid  (w_valid),
        .w_ready  (w_ready),
        .w        (w),
        .b_valid  (b_valid),
        .b_ready  (b_ready),
        .b        (b),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar       (ar),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r        (r),
        .rd_req   (rd_req),
        .rd_rsp   (rd_rsp),
        .wr_req   (wr_req),
        .wr_err   (wr_err)
    );

    uart_ctrl_status u_ctrl (
        .clk      (clk),
        .rst      (rst),
        .rd_req   (rd_req),
        .wr_req   (wr_req),
        .rd_rsp   (rd_rsp),
        .wr_err   (wr_err),
        .rx_avail (rx_avail),
        .rx_data  (rx_data),
        .rx_full  (!rx_in_ready),
        .rx_drop  (rx_drop),
        .rx_pop   (rx_pop),
        .rx_clear (rx_clear),
        .tx_empty (!tx_valid),
        .tx_full  (!tx_in_ready),
        .tx_push  (tx_push),
        .tx_data  (tx_data),
        .tx_clear (tx_clear),
        .intr     (intr)
    );

    uart_char_fifo #(
        .DEPTH (`UART_RX_DEPTH)
    ) rx_fifo (
        .clk       (clk),
        .rst       (rst),
        .clear     (rx_clear),
        .in_valid  (rx_valid),
        .in_ready  (rx_in_ready),
        .in_data   (rx_ch),
        .out_valid (rx_avail),
        .out_ready (rx_pop),
        .out_data  (rx_data)
    );

    uart_char_fifo #(
        .DEPTH (`UART_TX_DEPTH)
    ) tx_fifo (
        .clk       (clk),
        .rst       (rst),
        .clear     (tx_clear),
        .in_valid  (tx_push),
        .in_ready  (tx_in_ready),
        .in_data   (tx_data),
        .out_valid (tx_valid),
        .out_ready (tx_ready),
        .out_data  (tx_ch)
    );

endmodule

//--- src/uart_ctrl_status.sv
`timescale 1ns/1ps

module uart_ctrl_status (
    input  logic                        clk,
    input  logic                        rst,
    input  uart_emu_pkg::uart_rd_req_t  rd_req,
    input  uart_emu_pkg::uart_wr_req_t  wr_req,
    output uart_emu_pkg::axil_r_t       rd_rsp,
    output logic                        wr_err,
    input  logic                        rx_avail,
    input  uart_emu_pkg::uart_char_t    rx_data,
    input  logic                        rx_full,
    input  logic                        rx_drop,
    output logic                        rx_pop,
    output logic                        rx_clear,
    input  logic                        tx_empty,
    input  logic                        tx_full,
    output logic                        tx_push,
    output uart_emu_pkg::uart_char_t    tx_data,
    output logic                        tx_clear,
    output logic                        intr
);

    uart_emu_pkg::uart_stat_t stat;

    logic intr_en;
    logic overrun;
    logic rx_avail_q;
    logic tx_empty_q;
    logic wr_tx;
    logic wr_ctrl;
    logic stat_rd;

    // A cleared strobe bit turns the write into a no-op
    assign wr_tx   = wr_req.valid && wr_req.strb && (wr_req.sel == uart_emu_pkg::TX_DATA);
    assign wr_ctrl = wr_req.valid && wr_req.strb && (wr_req.sel == uart_emu_pkg::CTRL);
    assign stat_rd = rd_req.valid && (rd_req.sel == uart_emu_pkg::STAT);

    assign wr_err   = wr_tx && tx_full;
    assign tx_push  = wr_tx && !tx_full;
    assign tx_data  = wr_req.data;
    assign tx_clear = wr_ctrl && wr_req.data[0];
    assign rx_clear = wr_ctrl && wr_req.data[1];
    assign rx_pop   = rd_req.valid && (rd_req.sel == uart_emu_pkg::RX_DATA) && rx_avail;

    always_ff @(posedge clk) begin
        if (rst) begin
            intr_en <= 1'b0;
            overrun <= 1'b0;
        end else begin
            if (wr_ctrl) begin
                intr_en <= wr_req.data[4];
            end
            // New drop wins over the clear on read
            if (rx_drop) begin
                overrun <= 1'b1;
            end else if (stat_rd) begin
                overrun <= 1'b0;
            end
        end
    end

    assign stat.overrun  = overrun;
    assign stat.intr_en  = intr_en;
    assign stat.tx_full  = tx_full;
    assign stat.tx_empty = tx_empty;
    assign stat.rx_full  = rx_full;
    assign stat.rx_avail = rx_avail;

    always_comb begin
        rd_rsp.data = '0;
        rd_rsp.resp = uart_emu_pkg::AXIL_OKAY;
        case (rd_req.sel)
            uart_emu_pkg::RX_DATA: begin
                if (rx_avail) begin
                    rd_rsp.data = {24'd0, rx_data};
                end else begin
                    rd_rsp.resp = uart_emu_pkg::AXIL_SLVERR;
                end
            end
            uart_emu_pkg::STAT: rd_rsp.data = {26'd0, stat};
            uart_emu_pkg::CTRL: rd_rsp.data = {27'd0, intr_en, 4'd0};
            default:            rd_rsp.data = '0;
        endcase
    end

    // Edge detect, pulse lands one cycle after the edge
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_avail_q <= 1'b0;
            tx_empty_q <= 1'b1;
            intr       <= 1'b0;
        end else begin
            rx_avail_q <= rx_avail;
            tx_empty_q <= tx_empty;
            intr       <= intr_en && ((rx_avail && !rx_avail_q) || (tx_empty && !tx_empty_q));
        end
    end

endmodule

//--- src/uart_axil_slave.sv
`timescale 1ns/1ps

module uart_axil_slave (
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        aw_valid,
    output logic                        aw_ready,
    input  uart_emu_pkg::axil_aw_t      aw,
    input  logic                        w_valid,
    output logic                        w_ready,
    input  uart_emu_pkg::axil_w_t       w,
    output logic                        b_valid,
    input  logic                        b_ready,
    output uart_emu_pkg::axil_b_t       b,

    input  logic                        ar_valid,
    output logic                        ar_ready,
    input  uart_emu_pkg::axil_ar_t      ar,
    output logic                        r_valid,
    input  logic                        r_ready,
    output uart_emu_pkg::axil_r_t       r,

    output uart_emu_pkg::uart_rd_req_t  rd_req,
    input  uart_emu_pkg::axil_r_t       rd_rsp,
    output uart_emu_pkg::uart_wr_req_t  wr_req,
    input  logic                        wr_err
);

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_REQ,
        RD_RESP
    } rd_state_e;

    typedef enum logic [1:0] {
        WR_ADDR,
        WR_DATA,
        WR_EXEC,
        WR_RESP
    } wr_state_e;

    rd_state_e rd_state;
    wr_state_e wr_state;

    uart_emu_pkg::uart_reg_sel_e rd_sel;
    uart_emu_pkg::uart_reg_sel_e wr_sel;
    uart_emu_pkg::uart_char_t    wr_data;
    logic                        wr_strb;

    // Read side
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state <= RD_IDLE;
        end else begin
            case (rd_state)
                RD_IDLE: begin
                    if (ar_valid) begin
                        rd_state <= RD_REQ;
                    end
                end
                RD_REQ:  rd_state <= RD_RESP;
                RD_RESP: begin
                    if (r_ready) begin
                        rd_state <= RD_IDLE;
                    end
                end
                default: rd_state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_valid && ar_ready) begin
            rd_sel <= uart_emu_pkg::uart_reg_sel_e'(ar.addr[3:2]);
        end
        // Response captured in the same cycle as the strobe
        if (rd_state == RD_REQ) begin
            r <= rd_rsp;
        end
    end

    assign ar_ready     = (rd_state == RD_IDLE);
    assign r_valid      = (rd_state == RD_RESP);
    assign rd_req.valid = (rd_state == RD_REQ);
    assign rd_req.sel   = rd_sel;

    // Write side
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state <= WR_ADDR;
        end else begin
            case (wr_state)
                WR_ADDR: begin
                    if (aw_valid) begin
                        wr_state <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (w_valid) begin
                        wr_state <= WR_EXEC;
                    end
                end
                WR_EXEC: wr_state <= WR_RESP;
                WR_RESP: begin
                    if (b_ready) begin
                        wr_state <= WR_ADDR;
                    end
                end
                default: wr_state <= WR_ADDR;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_valid && aw_ready) begin
            wr_sel <= uart_emu_pkg::uart_reg_sel_e'(aw.addr[3:2]);
        end
        // Only the low byte lane reaches the registers
        if (w_valid && w_ready) begin
            wr_data <= w.data[7:0];
            wr_strb <= w.strb[0];
        end
        if (wr_state == WR_EXEC) begin
            b.resp <= wr_err ? uart_emu_pkg::AXIL_SLVERR : uart_emu_pkg::AXIL_OKAY;
        end
    end

    assign aw_ready     = (wr_state == WR_ADDR);
    assign w_ready      = (wr_state == WR_DATA);
    assign b_valid      = (wr_state == WR_RESP);
    assign wr_req.valid = (wr_state == WR_EXEC);
    assign wr_req.sel   = wr_sel;
    assign wr_req.data  = wr_data;
    assign wr_req.strb  = wr_strb;

endmodule

//--- src/uart_char_fifo.sv
`timescale 1ns/1ps

module uart_char_fifo #(
    parameter int DEPTH = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    clear,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  uart_emu_pkg::uart_char_t in_data,
    output logic                    out_valid,
    input  logic                    out_ready,
    output uart_emu_pkg::uart_char_t out_data
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    uart_emu_pkg::uart_char_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign in_ready  = (count != CNT_W'(DEPTH));
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

    // Pointers wrap at DEPTH, which need not be a power of two
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- src/uart_emu_pkg.sv
`include "uart_emu_settings.svh"

package uart_emu_pkg;

    localparam logic [1:0] AXIL_OKAY   = 2'b00;
    localparam logic [1:0] AXIL_SLVERR = 2'b10;

    typedef logic [7:0] uart_char_t;

    typedef struct packed {
        logic [`UART_ADDR_W-1:0] addr;
    } axil_aw_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
    } axil_w_t;

    typedef struct packed {
        logic [`UART_ADDR_W-1:0] addr;
    } axil_ar_t;

    typedef struct packed {
        logic [31:0] data;
        logic [1:0]  resp;
    } axil_r_t;

    typedef struct packed {
        logic [1:0] resp;
    } axil_b_t;

    // Word index of each register, address bits 3:2
    typedef enum logic [1:0] {
        RX_DATA = 2'(`UART_OFS_RX >> 2),
        TX_DATA = 2'(`UART_OFS_TX >> 2),
        STAT    = 2'(`UART_OFS_STAT >> 2),
        CTRL    = 2'(`UART_OFS_CTRL >> 2)
    } uart_reg_sel_e;

    typedef struct packed {
        logic          valid;
        uart_reg_sel_e sel;
        uart_char_t    data;
        logic          strb;
    } uart_wr_req_t;

    typedef struct packed {
        logic          valid;
        uart_reg_sel_e sel;
    } uart_rd_req_t;

    // Low six bits of the status word, rx_avail at bit 0
    typedef struct packed {
        logic overrun;
        logic intr_en;
        logic tx_full;
        logic tx_empty;
        logic rx_full;
        logic rx_avail;
    } uart_stat_t;

endpackage

//--- include/uart_emu_settings.svh
`ifndef UART_EMU_SETTINGS_SVH
`define UART_EMU_SETTINGS_SVH

// AXI-Lite address width, covers the four word registers
`define UART_ADDR_W 4

// FIFO depths in characters
`define UART_RX_DEPTH 16
`define UART_TX_DEPTH 16

// Register byte offsets
`define UART_OFS_RX   4'h0
`define UART_OFS_TX   4'h4
`define UART_OFS_STAT 4'h8
`define UART_OFS_CTRL 4'hC

`endif
